// File: include/intIq_cfg.svh
`ifndef INT_IQ_CFG_SVH
`define INT_IQ_CFG_SVH

// queue geometry
`define IQ_DEPTH        16
`define IQ_IDX_W        4
`define IQ_DISPATCH_W   4       // rename lanes per cycle
`define IQ_ISSUE_W      2       // alu ports
`define IQ_WAKE_W       3       // branch, csr, load

// field widths
`define IQ_TAG_W        6
`define IQ_ROB_W        6
`define IQ_OPC_W        8
`define IQ_IMM_W        12      // also the operand-2 word

`endif

// File: rtl/intIqPkg.sv
`include "intIq_cfg.svh"

package intIqPkg;

    // operand-2 word, the immediate flag picks the view
    typedef union packed {
        struct packed {
            logic [`IQ_IMM_W-`IQ_TAG_W-1:0] pad;
            logic [`IQ_TAG_W-1:0]           tag;    // src2 physical tag
        } regView;
        logic [`IQ_IMM_W-1:0] immView;
    } opnd2U;

endpackage

// File: rtl/iqFreeList.sv
`timescale 1ns/1ps
`include "intIq_cfg.svh"

module iqFreeList (
    input  logic                                        Clk,
    input  logic                                        rstN,
    input  logic                                        flush,
    input  logic                                        stop,
    input  logic [2:0]                                  allocNum,
    input  logic [`IQ_ISSUE_W-1:0]                      retValid,
    input  logic [`IQ_ISSUE_W-1:0][`IQ_IDX_W-1:0]       retIdx,
    output logic [`IQ_DISPATCH_W-1:0][`IQ_IDX_W-1:0]    freeIdx,
    output logic [`IQ_DISPATCH_W-1:0]                   freeValid,
    output logic                                        queueFull
);

    logic [`IQ_IDX_W-1:0]                   ring [`IQ_DEPTH];
    logic [`IQ_IDX_W-1:0]                   head;
    logic [`IQ_IDX_W-1:0]                   tail;
    logic [`IQ_IDX_W:0]                     count;      // free slots, 0..depth
    logic [2:0]                             allocTake;
    logic [`IQ_IDX_W:0]                     retCnt;
    logic [`IQ_ISSUE_W-1:0][`IQ_IDX_W-1:0]  retPos;

    assign allocTake = stop ? 3'd0 : allocNum;   // no allocation while stalled

    // returned slots pack densely at the tail
    always_comb begin
        retCnt = '0;
        for (int p = 0; p < `IQ_ISSUE_W; p++) begin
            retPos[p] = tail + retCnt[`IQ_IDX_W-1:0];
            retCnt    = retCnt + (`IQ_IDX_W+1)'(retValid[p]);
        end
    end

    always_ff @(posedge Clk) begin
        if (!rstN || flush) begin
            for (int i = 0; i < `IQ_DEPTH; i++) begin
                ring[i] <= (`IQ_IDX_W)'(i);
            end
            head  <= '0;
            tail  <= '0;
            count <= (`IQ_IDX_W+1)'(`IQ_DEPTH);
        end else begin
            for (int p = 0; p < `IQ_ISSUE_W; p++) begin
                if (retValid[p]) begin
                    ring[retPos[p]] <= retIdx[p];
                end
            end
            head  <= head + (`IQ_IDX_W)'(allocTake);
            tail  <= tail + retCnt[`IQ_IDX_W-1:0];
            count <= count - (`IQ_IDX_W+1)'(allocTake) + retCnt;
        end
    end

    // next free slots straight off the head
    always_comb begin
        for (int k = 0; k < `IQ_DISPATCH_W; k++) begin
            freeIdx[k]   = ring[head + (`IQ_IDX_W)'(k)];
            freeValid[k] = count > (`IQ_IDX_W+1)'(k);
        end
    end

    assign queueFull = ~freeValid[`IQ_DISPATCH_W-1];   // less than one full group

endmodule

// File: rtl/iqEntryArray.sv
`timescale 1ns/1ps
`include "intIq_cfg.svh"

module iqEntryArray (
    input  logic                                        Clk,
    input  logic                                        rstN,
    input  logic                                        flush,
    input  logic                                        stop,
    input  logic [`IQ_DISPATCH_W-1:0]                   dispValid,
    input  logic [`IQ_DISPATCH_W-1:0][`IQ_OPC_W-1:0]    dispOpcode,
    input  logic [`IQ_DISPATCH_W-1:0]                   dispSrc1Able,
    input  logic [`IQ_DISPATCH_W-1:0]                   dispSrc1Ready,
    input  logic [`IQ_DISPATCH_W-1:0][`IQ_TAG_W-1:0]    dispSrc1Tag,
    input  logic [`IQ_DISPATCH_W-1:0]                   dispImmAble,
    input  intIqPkg::opnd2U [`IQ_DISPATCH_W-1:0]        dispOpnd2,
    input  logic [`IQ_DISPATCH_W-1:0]                   dispSrc2Ready,
    input  logic [`IQ_DISPATCH_W-1:0]                   dispRdAble,
    input  logic [`IQ_DISPATCH_W-1:0][`IQ_TAG_W-1:0]    dispRdTag,
    input  logic [`IQ_DISPATCH_W-1:0][`IQ_ROB_W-1:0]    dispRobPtr,
    input  logic [`IQ_DISPATCH_W-1:0][`IQ_IDX_W-1:0]    freeIdx,
    input  logic [`IQ_DISPATCH_W-1:0]                   freeValid,
    input  logic [`IQ_WAKE_W-1:0]                       wakeValid,
    input  logic [`IQ_WAKE_W-1:0][`IQ_TAG_W-1:0]        wakeTag,
    input  logic [`IQ_ISSUE_W-1:0]                      selfWakeValid,
    input  logic [`IQ_ISSUE_W-1:0][`IQ_TAG_W-1:0]       selfWakeTag,
    input  logic [`IQ_ISSUE_W-1:0]                      clrValid,
    input  logic [`IQ_ISSUE_W-1:0][`IQ_IDX_W-1:0]       clrIdx,
    output logic [2:0]                                  allocNum,
    output logic [`IQ_DEPTH-1:0]                        readyVec,
    output logic [`IQ_DEPTH-1:0][`IQ_OPC_W-1:0]         entOpcode,
    output logic [`IQ_DEPTH-1:0]                        entSrc1Able,
    output logic [`IQ_DEPTH-1:0][`IQ_TAG_W-1:0]         entSrc1Tag,
    output logic [`IQ_DEPTH-1:0]                        entImmAble,
    output intIqPkg::opnd2U [`IQ_DEPTH-1:0]             entOpnd2,
    output logic [`IQ_DEPTH-1:0]                        entRdAble,
    output logic [`IQ_DEPTH-1:0][`IQ_TAG_W-1:0]         entRdTag,
    output logic [`IQ_DEPTH-1:0][`IQ_ROB_W-1:0]         entRobPtr
);

    logic [`IQ_DEPTH-1:0]       entValid;
    logic [`IQ_DEPTH-1:0]       entSrc1Ready;
    logic [`IQ_DEPTH-1:0]       entSrc2Ready;
    logic [`IQ_DISPATCH_W-1:0]  laneGo;

    // external buses plus the two issued rd tags
    function automatic logic tagHit(input logic [`IQ_TAG_W-1:0] tag);
        logic hit;
        hit = 1'b0;
        for (int w = 0; w < `IQ_WAKE_W; w++) begin
            hit |= wakeValid[w] && (wakeTag[w] == tag);
        end
        for (int p = 0; p < `IQ_ISSUE_W; p++) begin
            hit |= selfWakeValid[p] && (selfWakeTag[p] == tag);
        end
        return hit;
    endfunction

    // lanes accepted only as a contiguous run from lane 0
    always_comb begin
        logic chain;
        chain    = !stop;
        allocNum = '0;
        for (int k = 0; k < `IQ_DISPATCH_W; k++) begin
            chain     = chain && dispValid[k] && freeValid[k];
            laneGo[k] = chain;
            allocNum  = allocNum + 3'(chain);
        end
    end

    always_ff @(posedge Clk) begin
        if (!rstN || flush) begin
            entValid <= '0;
        end else begin
            for (int p = 0; p < `IQ_ISSUE_W; p++) begin
                if (clrValid[p]) begin
                    entValid[clrIdx[p]] <= 1'b0;
                end
            end
            for (int k = 0; k < `IQ_DISPATCH_W; k++) begin
                if (laneGo[k]) begin
                    entValid[freeIdx[k]] <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge Clk) begin
        // wakeup on stored sources
        for (int e = 0; e < `IQ_DEPTH; e++) begin
            if (entValid[e] && tagHit(entSrc1Tag[e])) begin
                entSrc1Ready[e] <= 1'b1;
            end
            if (entValid[e] && !entImmAble[e] && tagHit(entOpnd2[e].regView.tag)) begin
                entSrc2Ready[e] <= 1'b1;
            end
        end
        // dispatch writes, catching a broadcast in the same cycle
        for (int k = 0; k < `IQ_DISPATCH_W; k++) begin
            if (laneGo[k]) begin
                entOpcode[freeIdx[k]]    <= dispOpcode[k];
                entSrc1Able[freeIdx[k]]  <= dispSrc1Able[k];
                entSrc1Tag[freeIdx[k]]   <= dispSrc1Tag[k];
                entImmAble[freeIdx[k]]   <= dispImmAble[k];
                entOpnd2[freeIdx[k]]     <= dispOpnd2[k];
                entRdAble[freeIdx[k]]    <= dispRdAble[k];
                entRdTag[freeIdx[k]]     <= dispRdTag[k];
                entRobPtr[freeIdx[k]]    <= dispRobPtr[k];
                entSrc1Ready[freeIdx[k]] <= dispSrc1Ready[k] || !dispSrc1Able[k]
                                            || tagHit(dispSrc1Tag[k]);
                entSrc2Ready[freeIdx[k]] <= dispSrc2Ready[k] || dispImmAble[k]
                                            || tagHit(dispOpnd2[k].regView.tag);
            end
        end
    end

    assign readyVec = entValid & entSrc1Ready & entSrc2Ready;

endmodule

// File: rtl/iqSelect.sv
`timescale 1ns/1ps
`include "intIq_cfg.svh"

module iqSelect (
    input  logic                                        Clk,
    input  logic                                        rstN,
    input  logic                                        flush,
    input  logic                                        stop,
    input  logic [`IQ_DEPTH-1:0]                        readyVec,
    input  logic [`IQ_DEPTH-1:0][`IQ_OPC_W-1:0]         entOpcode,
    input  logic [`IQ_DEPTH-1:0]                        entSrc1Able,
    input  logic [`IQ_DEPTH-1:0][`IQ_TAG_W-1:0]         entSrc1Tag,
    input  logic [`IQ_DEPTH-1:0]                        entImmAble,
    input  intIqPkg::opnd2U [`IQ_DEPTH-1:0]             entOpnd2,
    input  logic [`IQ_DEPTH-1:0]                        entRdAble,
    input  logic [`IQ_DEPTH-1:0][`IQ_TAG_W-1:0]         entRdTag,
    input  logic [`IQ_DEPTH-1:0][`IQ_ROB_W-1:0]         entRobPtr,
    output logic [`IQ_ISSUE_W-1:0]                      clrValid,
    output logic [`IQ_ISSUE_W-1:0][`IQ_IDX_W-1:0]       clrIdx,
    output logic [`IQ_ISSUE_W-1:0]                      selfWakeValid,
    output logic [`IQ_ISSUE_W-1:0][`IQ_TAG_W-1:0]       selfWakeTag,
    output logic [`IQ_ISSUE_W-1:0]                      issueValid,
    output logic [`IQ_ISSUE_W-1:0][`IQ_OPC_W-1:0]       issueOpcode,
    output logic [`IQ_ISSUE_W-1:0]                      issueSrc1Able,
    output logic [`IQ_ISSUE_W-1:0][`IQ_TAG_W-1:0]       issueSrc1Tag,
    output logic [`IQ_ISSUE_W-1:0]                      issueImmAble,
    output intIqPkg::opnd2U [`IQ_ISSUE_W-1:0]           issueOpnd2,
    output logic [`IQ_ISSUE_W-1:0]                      issueRdAble,
    output logic [`IQ_ISSUE_W-1:0][`IQ_TAG_W-1:0]       issueRdTag,
    output logic [`IQ_ISSUE_W-1:0][`IQ_ROB_W-1:0]       issueRobPtr
);

    // one lowest-slot-first search per port, port 0 gets the lower slot
    always_comb begin
        logic [`IQ_DEPTH-1:0] avail;
        avail    = readyVec & {`IQ_DEPTH{!stop && !flush}};
        clrValid = '0;
        clrIdx   = '0;
        for (int p = 0; p < `IQ_ISSUE_W; p++) begin
            for (int e = 0; e < `IQ_DEPTH; e++) begin
                if (avail[e] && !clrValid[p]) begin
                    clrValid[p] = 1'b1;
                    clrIdx[p]   = (`IQ_IDX_W)'(e);
                end
            end
            if (clrValid[p]) begin
                avail[clrIdx[p]] = 1'b0;   // taken by an earlier port
            end
        end
    end

    // broadcast at the issue edge so dependents can go next cycle
    always_comb begin
        for (int p = 0; p < `IQ_ISSUE_W; p++) begin
            selfWakeValid[p] = clrValid[p] && entRdAble[clrIdx[p]];
            selfWakeTag[p]   = entRdTag[clrIdx[p]];
        end
    end

    always_ff @(posedge Clk) begin
        if (!rstN) begin
            issueValid <= '0;
        end else begin
            issueValid <= clrValid;
        end
    end

    always_ff @(posedge Clk) begin
        for (int p = 0; p < `IQ_ISSUE_W; p++) begin
            issueOpcode[p]   <= entOpcode[clrIdx[p]];
            issueSrc1Able[p] <= entSrc1Able[clrIdx[p]];
            issueSrc1Tag[p]  <= entSrc1Tag[clrIdx[p]];
            issueImmAble[p]  <= entImmAble[clrIdx[p]];
            issueOpnd2[p]    <= entOpnd2[clrIdx[p]];
            issueRdAble[p]   <= entRdAble[clrIdx[p]];
            issueRdTag[p]    <= entRdTag[clrIdx[p]];
            issueRobPtr[p]   <= entRobPtr[clrIdx[p]];
        end
    end

endmodule

// File: rtl/intIssueQueue.sv
`timescale 1ns/1ps
`include "intIq_cfg.svh"

module intIssueQueue (
    input  logic                                        Clk,
    input  logic                                        rstN,
    input  logic                                        stop,
    input  logic                                        flush,
    input  logic [`IQ_DISPATCH_W-1:0]                   dispValid,
    input  logic [`IQ_DISPATCH_W-1:0][`IQ_OPC_W-1:0]    dispOpcode,
    input  logic [`IQ_DISPATCH_W-1:0]                   dispSrc1Able,
    input  logic [`IQ_DISPATCH_W-1:0]                   dispSrc1Ready,
    input  logic [`IQ_DISPATCH_W-1:0][`IQ_TAG_W-1:0]    dispSrc1Tag,
    input  logic [`IQ_DISPATCH_W-1:0]                   dispImmAble,
    input  intIqPkg::opnd2U [`IQ_DISPATCH_W-1:0]        dispOpnd2,
    input  logic [`IQ_DISPATCH_W-1:0]                   dispSrc2Ready,
    input  logic [`IQ_DISPATCH_W-1:0]                   dispRdAble,
    input  logic [`IQ_DISPATCH_W-1:0][`IQ_TAG_W-1:0]    dispRdTag,
    input  logic [`IQ_DISPATCH_W-1:0][`IQ_ROB_W-1:0]    dispRobPtr,
    input  logic [`IQ_WAKE_W-1:0]                       wakeValid,
    input  logic [`IQ_WAKE_W-1:0][`IQ_TAG_W-1:0]        wakeTag,
    output logic [`IQ_ISSUE_W-1:0]                      issueValid,
    output logic [`IQ_ISSUE_W-1:0][`IQ_OPC_W-1:0]       issueOpcode,
    output logic [`IQ_ISSUE_W-1:0]                      issueSrc1Able,
    output logic [`IQ_ISSUE_W-1:0][`IQ_TAG_W-1:0]       issueSrc1Tag,
    output logic [`IQ_ISSUE_W-1:0]                      issueImmAble,
    output intIqPkg::opnd2U [`IQ_ISSUE_W-1:0]           issueOpnd2,
    output logic [`IQ_ISSUE_W-1:0]                      issueRdAble,
    output logic [`IQ_ISSUE_W-1:0][`IQ_TAG_W-1:0]       issueRdTag,
    output logic [`IQ_ISSUE_W-1:0][`IQ_ROB_W-1:0]       issueRobPtr,
    output logic                                        queueFull
);

    import intIqPkg::*;

    // free list to entry array
    logic [2:0]                             allocNum;
    logic [`IQ_DISPATCH_W-1:0][`IQ_IDX_W-1:0] freeIdx;
    logic [`IQ_DISPATCH_W-1:0]              freeValid;

    // stored entries to select
    logic [`IQ_DEPTH-1:0]                   readyVec;
    logic [`IQ_DEPTH-1:0][`IQ_OPC_W-1:0]    entOpcode;
    logic [`IQ_DEPTH-1:0]                   entSrc1Able;
    logic [`IQ_DEPTH-1:0][`IQ_TAG_W-1:0]    entSrc1Tag;
    logic [`IQ_DEPTH-1:0]                   entImmAble;
    opnd2U [`IQ_DEPTH-1:0]                  entOpnd2;
    logic [`IQ_DEPTH-1:0]                   entRdAble;
    logic [`IQ_DEPTH-1:0][`IQ_TAG_W-1:0]    entRdTag;
    logic [`IQ_DEPTH-1:0][`IQ_ROB_W-1:0]    entRobPtr;

    // select back to the array and the ring
    logic [`IQ_ISSUE_W-1:0]                 clrValid;
    logic [`IQ_ISSUE_W-1:0][`IQ_IDX_W-1:0]  clrIdx;
    logic [`IQ_ISSUE_W-1:0]                 selfWakeValid;
    logic [`IQ_ISSUE_W-1:0][`IQ_TAG_W-1:0]  selfWakeTag;

    iqFreeList iqFreeList_i (
        .*,
        .retValid (clrValid),   // issued slots go back to the ring
        .retIdx   (clrIdx)
    );

    iqEntryArray iqEntryArray_i (
        .*
    );

    iqSelect iqSelect_i (
        .*
    );

endmodule

// File: sim/intIssueQueueTb.sv
`timescale 1ns/1ps
`include "intIq_cfg.svh"

module intIssueQueueTb;

    import intIqPkg::*;

    localparam int NROW = 48;
    localparam int NROB = 64;
    localparam int BIG  = 1000000;
    localparam logic [`IQ_TAG_W-1:0] RND = '0;    // tag 0 means pick a harmless random tag

    typedef struct packed {
        logic                 s1Able;
        logic                 s1Rdy;
        logic [`IQ_TAG_W-1:0] s1Tag;
        logic                 imm;
        logic                 s2Rdy;
        logic [`IQ_TAG_W-1:0] s2Tag;
        logic                 rdAble;
        logic [`IQ_TAG_W-1:0] rdTag;
    } laneT;

    logic                                        Clk;
    logic                                        rstN;
    logic                                        stop;
    logic                                        flush;
    logic [`IQ_DISPATCH_W-1:0]                   dispValid;
    logic [`IQ_DISPATCH_W-1:0][`IQ_OPC_W-1:0]    dispOpcode;
    logic [`IQ_DISPATCH_W-1:0]                   dispSrc1Able;
    logic [`IQ_DISPATCH_W-1:0]                   dispSrc1Ready;
    logic [`IQ_DISPATCH_W-1:0][`IQ_TAG_W-1:0]    dispSrc1Tag;
    logic [`IQ_DISPATCH_W-1:0]                   dispImmAble;
    opnd2U [`IQ_DISPATCH_W-1:0]                  dispOpnd2;
    logic [`IQ_DISPATCH_W-1:0]                   dispSrc2Ready;
    logic [`IQ_DISPATCH_W-1:0]                   dispRdAble;
    logic [`IQ_DISPATCH_W-1:0][`IQ_TAG_W-1:0]    dispRdTag;
    logic [`IQ_DISPATCH_W-1:0][`IQ_ROB_W-1:0]    dispRobPtr;
    logic [`IQ_WAKE_W-1:0]                       wakeValid;
    logic [`IQ_WAKE_W-1:0][`IQ_TAG_W-1:0]        wakeTag;
    logic [`IQ_ISSUE_W-1:0]                      issueValid;
    logic [`IQ_ISSUE_W-1:0][`IQ_OPC_W-1:0]       issueOpcode;
    logic [`IQ_ISSUE_W-1:0]                      issueSrc1Able;
    logic [`IQ_ISSUE_W-1:0][`IQ_TAG_W-1:0]       issueSrc1Tag;
    logic [`IQ_ISSUE_W-1:0]                      issueImmAble;
    opnd2U [`IQ_ISSUE_W-1:0]                     issueOpnd2;
    logic [`IQ_ISSUE_W-1:0]                      issueRdAble;
    logic [`IQ_ISSUE_W-1:0][`IQ_TAG_W-1:0]       issueRdTag;
    logic [`IQ_ISSUE_W-1:0][`IQ_ROB_W-1:0]       issueRobPtr;
    logic                                        queueFull;

    // stimulus table with one row per cycle
    laneT                 rowLane  [NROW][`IQ_DISPATCH_W];
    int                   rowLanes [NROW];
    logic                 rowStop  [NROW];
    logic                 rowFlush [NROW];
    logic [`IQ_WAKE_W-1:0] rowWakeV [NROW];
    logic [`IQ_TAG_W-1:0] rowWakeT [NROW][`IQ_WAKE_W];
    int                   rowCnt;
    int                   nTable;

    // scoreboard indexed by robPtr
    // sbR1 and sbR2 hold the edge where a source became ready
    logic                 sbLive  [NROB];
    logic                 sbDone  [NROB];
    int                   sbDisp  [NROB];
    int                   sbR1    [NROB];
    int                   sbR2    [NROB];
    logic [`IQ_OPC_W-1:0] sbOpc   [NROB];
    logic                 sbS1Able[NROB];
    logic [`IQ_TAG_W-1:0] sbS1Tag [NROB];
    logic                 sbImm   [NROB];
    opnd2U                sbOp2   [NROB];
    logic                 sbRdAble[NROB];
    logic [`IQ_TAG_W-1:0] sbRdTag [NROB];

    int   seed;
    int   cyc;
    int   runCnt;
    int   limit;
    int   inQueue;
    int   nextRob;
    int   errCount;
    logic stopPrev;
    logic flushPrev;

    intIssueQueue intIssueQueue_i (.*);

    initial begin
        Clk = 1'b0;
        forever #5 Clk = ~Clk;
    end

    task automatic failWith(input string msg);
        errCount++;
        $display("%0t ns: %s", $time, msg);
        $display("Simulation FAILED");
        $fatal(1);
    endtask

    task automatic checkEq(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            errCount++;
            $display("[FAIL] %0t ns %s: got %0h expected %0h", $time, name, got, exp);
            $display("Simulation FAILED");
            $fatal(1);
        end
    endtask

    always @(posedge Clk) begin
        cyc <= cyc + 1;
        if (rstN) begin
            runCnt <= runCnt + 1;
            if (runCnt > limit) begin
                failWith("timeout, queue did not drain in time");
            end
        end
    end

    function automatic logic [`IQ_TAG_W-1:0] pickTag(input logic [`IQ_TAG_W-1:0] t);
        logic [31:0] rnd;
        rnd = $random(seed);
        return (t == RND) ? {2'b11, rnd[3:0]} : t;    // 48..63 never waited on
    endfunction

    function automatic laneT mkLane(input logic s1Able, input logic s1Rdy,
                                    input logic [`IQ_TAG_W-1:0] s1Tag, input logic imm,
                                    input logic s2Rdy, input logic [`IQ_TAG_W-1:0] s2Tag,
                                    input logic rdAble, input logic [`IQ_TAG_W-1:0] rdTag);
        laneT ln;
        ln.s1Able = s1Able;
        ln.s1Rdy  = s1Rdy;
        ln.s1Tag  = s1Tag;
        ln.imm    = imm;
        ln.s2Rdy  = s2Rdy;
        ln.s2Tag  = s2Tag;
        ln.rdAble = rdAble;
        ln.rdTag  = rdTag;
        return ln;
    endfunction

    task automatic newRow(input logic s, input logic f);
        rowLanes[rowCnt] = 0;
        rowStop[rowCnt]  = s;
        rowFlush[rowCnt] = f;
        rowWakeV[rowCnt] = '0;
        for (int w = 0; w < `IQ_WAKE_W; w++) rowWakeT[rowCnt][w] = '0;
        for (int k = 0; k < `IQ_DISPATCH_W; k++) rowLane[rowCnt][k] = '0;
        rowCnt++;
    endtask

    task automatic addLane(input laneT ln);
        rowLane[rowCnt-1][rowLanes[rowCnt-1]] = ln;
        rowLanes[rowCnt-1]++;
    endtask

    task automatic addWake(input int bus, input logic [`IQ_TAG_W-1:0] tag);
        rowWakeV[rowCnt-1][bus] = 1'b1;
        rowWakeT[rowCnt-1][bus] = tag;
    endtask

    task automatic idleRows(input int n);
        repeat (n) newRow(1'b0, 1'b0);
    endtask

    task automatic applyWake(input logic [`IQ_TAG_W-1:0] tag, input int w);
        for (int r = 0; r < NROB; r++) begin
            if (sbLive[r] && !sbDone[r] && sbDisp[r] <= w) begin
                if (sbR1[r] == BIG && sbS1Tag[r] == tag) sbR1[r] = w;
                if (sbR2[r] == BIG && !sbImm[r] && sbOp2[r].regView.tag == tag) sbR2[r] = w;
            end
        end
    endtask

    task automatic processIssues(input int e);
        int r;
        for (int p = 0; p < `IQ_ISSUE_W; p++) begin
            if (issueValid[p]) begin
                r = int'(issueRobPtr[p]);
                if (stopPrev || flushPrev) begin
                    failWith("a micro-op issued while stop or flush was high");
                end
                if (!sbLive[r]) begin
                    failWith($sformatf("robPtr %0d issued but is not in the queue", r));
                end
                if (sbDone[r]) failWith($sformatf("robPtr %0d issued a second time", r));
                if (e < sbDisp[r] + 1) failWith($sformatf("robPtr %0d issued too early", r));
                if (sbR1[r] >= e || sbR2[r] >= e) begin
                    failWith($sformatf("robPtr %0d issued before its sources were woken", r));
                end
                checkEq($sformatf("issueOpcode[%0d]", p),
                        32'(issueOpcode[p]), 32'(sbOpc[r]));
                checkEq($sformatf("issueSrc1Able[%0d]", p),
                        32'(issueSrc1Able[p]), 32'(sbS1Able[r]));
                checkEq($sformatf("issueSrc1Tag[%0d]", p),
                        32'(issueSrc1Tag[p]), 32'(sbS1Tag[r]));
                checkEq($sformatf("issueImmAble[%0d]", p),
                        32'(issueImmAble[p]), 32'(sbImm[r]));
                if (sbImm[r]) begin
                    checkEq($sformatf("issueOpnd2[%0d].immView", p),
                            32'(issueOpnd2[p].immView), 32'(sbOp2[r].immView));
                end else begin
                    checkEq($sformatf("issueOpnd2[%0d].regView.tag", p),
                            32'(issueOpnd2[p].regView.tag), 32'(sbOp2[r].regView.tag));
                end
                checkEq($sformatf("issueRdAble[%0d]", p),
                        32'(issueRdAble[p]), 32'(sbRdAble[r]));
                checkEq($sformatf("issueRdTag[%0d]", p),
                        32'(issueRdTag[p]), 32'(sbRdTag[r]));
                sbDone[r] = 1'b1;
                inQueue--;
            end
        end
        // issued rd tags wake dependents at the issue edge
        for (int p = 0; p < `IQ_ISSUE_W; p++) begin
            if (issueValid[p]) begin
                r = int'(issueRobPtr[p]);
                if (sbRdAble[r]) applyWake(sbRdTag[r], e);
            end
        end
    endtask

    task automatic driveRow(input int r, input int e);
        int          acc;
        logic [31:0] rnd;
        laneT        ln;
        acc   = `IQ_DEPTH - inQueue;    // free slots at this edge
        acc   = (rowStop[r] || rowFlush[r]) ? 0 : ((rowLanes[r] < acc) ? rowLanes[r] : acc);
        stop  = rowStop[r];
        flush = rowFlush[r];
        for (int k = 0; k < `IQ_DISPATCH_W; k++) begin
            ln  = rowLane[r][k];
            rnd = $random(seed);
            dispValid[k]     = (k < rowLanes[r]);
            dispOpcode[k]    = rnd[`IQ_OPC_W-1:0];
            dispSrc1Able[k]  = ln.s1Able;
            dispSrc1Ready[k] = ln.s1Rdy;
            dispSrc1Tag[k]   = pickTag(ln.s1Tag);
            dispImmAble[k]   = ln.imm;
            rnd = $random(seed);
            if (ln.imm) begin
                dispOpnd2[k].immView = rnd[`IQ_IMM_W-1:0];
            end else begin
                dispOpnd2[k].regView.pad = rnd[`IQ_IMM_W-`IQ_TAG_W-1:0];
                dispOpnd2[k].regView.tag = pickTag(ln.s2Tag);
            end
            dispSrc2Ready[k] = ln.s2Rdy;
            dispRdAble[k]    = ln.rdAble;
            dispRdTag[k]     = pickTag(ln.rdTag);
            dispRobPtr[k]    = `IQ_ROB_W'(nextRob);
            if (k < acc) begin
                sbLive[nextRob]   = 1'b1;
                sbDone[nextRob]   = 1'b0;
                sbDisp[nextRob]   = e;
                sbOpc[nextRob]    = dispOpcode[k];
                sbS1Able[nextRob] = ln.s1Able;
                sbS1Tag[nextRob]  = dispSrc1Tag[k];
                sbImm[nextRob]    = ln.imm;
                sbOp2[nextRob]    = dispOpnd2[k];
                sbRdAble[nextRob] = ln.rdAble;
                sbRdTag[nextRob]  = dispRdTag[k];
                sbR1[nextRob]     = (ln.s1Rdy || !ln.s1Able) ? -1 : BIG;
                sbR2[nextRob]     = (ln.s2Rdy || ln.imm) ? -1 : BIG;
                inQueue++;
            end
            if (k < rowLanes[r]) nextRob++;
        end
        for (int w = 0; w < `IQ_WAKE_W; w++) begin
            wakeValid[w] = rowWakeV[r][w];
            wakeTag[w]   = rowWakeT[r][w];
            if (rowWakeV[r][w]) applyWake(rowWakeT[r][w], e);
        end
        stopPrev  = rowStop[r];
        flushPrev = rowFlush[r];
    endtask

    task automatic stepCycle(input int r);
        processIssues(cyc);
        if (flushPrev) begin
            for (int i = 0; i < NROB; i++) sbLive[i] = 1'b0;
            inQueue = 0;
        end
        checkEq("queueFull", 32'(queueFull), 32'((`IQ_DEPTH - inQueue) < `IQ_DISPATCH_W));
        driveRow(r, cyc + 1);
    endtask

    initial begin
        seed = 96;
        cyc = 0;
        runCnt = 0;
        limit = BIG;
        inQueue = 0;
        nextRob = 0;
        errCount = 0;
        rowCnt = 0;
        stopPrev = 1'b0;
        flushPrev = 1'b0;
        rstN = 1'b0;
        stop = 1'b0;
        flush = 1'b0;
        dispValid = '0;
        dispOpcode = '0;
        dispSrc1Able = '0;
        dispSrc1Ready = '0;
        dispSrc1Tag = '0;
        dispImmAble = '0;
        dispOpnd2 = '0;
        dispSrc2Ready = '0;
        dispRdAble = '0;
        dispRdTag = '0;
        dispRobPtr = '0;
        wakeValid = '0;
        wakeTag = '0;
        for (int i = 0; i < NROB; i++) begin
            sbLive[i] = 1'b0;
            sbDone[i] = 1'b0;
        end

        // ready at dispatch with one immediate and one lacking src1 and rd
        newRow(0, 0);
        addLane(mkLane(1, 1, RND, 0, 1, RND, 1, RND));
        addLane(mkLane(1, 1, RND, 1, 1, RND, 1, RND));
        addLane(mkLane(1, 1, RND, 0, 1, RND, 1, RND));
        addLane(mkLane(0, 0, RND, 0, 1, RND, 0, 6'd5));    // no rd so tag 5 stays asleep
        // waiting on external buses
        newRow(0, 0);
        addLane(mkLane(1, 0, 6'd5, 0, 1, RND, 1, RND));
        addLane(mkLane(1, 1, RND, 0, 0, 6'd6, 1, RND));
        idleRows(1);
        newRow(0, 0);
        addWake(0, 6'd5);
        newRow(0, 0);
        addWake(2, 6'd6);
        // producer chain through self wakeup
        newRow(0, 0);
        addLane(mkLane(1, 1, RND, 1, 1, RND, 1, 6'd20));
        addLane(mkLane(1, 0, 6'd20, 1, 1, RND, 1, 6'd21));
        addLane(mkLane(1, 1, RND, 0, 0, 6'd21, 1, RND));
        idleRows(2);
        // stop holds entries and drops new lanes
        newRow(0, 0);
        addLane(mkLane(1, 1, RND, 0, 1, RND, 1, RND));
        addLane(mkLane(1, 1, RND, 1, 1, RND, 1, RND));
        addLane(mkLane(1, 0, 6'd7, 0, 1, RND, 1, RND));
        addLane(mkLane(1, 1, RND, 0, 0, 6'd7, 1, RND));
        newRow(1, 0);
        addWake(1, 6'd7);
        for (int k = 0; k < `IQ_DISPATCH_W; k++) begin
            addLane(mkLane(1, 1, RND, 0, 1, RND, 1, RND));
        end
        newRow(1, 0);
        newRow(1, 0);
        idleRows(4);
        // fill all sixteen slots and then offer one more
        for (int g = 0; g < 4; g++) begin
            newRow(0, 0);
            for (int k = 0; k < `IQ_DISPATCH_W; k++) begin
                addLane(mkLane(1, 0, 6'd8, 0, 1, RND, 1, RND));
            end
        end
        newRow(0, 0);
        addLane(mkLane(1, 1, RND, 0, 1, RND, 1, RND));
        newRow(0, 0);
        addWake(0, 6'd8);
        idleRows(9);
        // flushed entries must stay silent
        newRow(0, 0);
        for (int k = 0; k < `IQ_DISPATCH_W; k++) begin
            addLane(mkLane(1, 1, RND, 0, 0, 6'd9, 1, RND));
        end
        newRow(0, 1);
        newRow(0, 0);
        addWake(1, 6'd9);
        idleRows(2);
        nTable = rowCnt;
        newRow(0, 0);           // blank row used for draining
        limit = nTable + 40;

        repeat (2) @(posedge Clk);
        @(negedge Clk);
        rstN = 1'b1;
        checkEq("issueValid", 32'(issueValid), 32'(0));
        checkEq("queueFull", 32'(queueFull), 32'(0));
        for (int r = 0; r < nTable; r++) begin
            stepCycle(r);
            @(negedge Clk);
        end
        while (inQueue != 0) begin
            stepCycle(nTable);
            @(negedge Clk);
        end
        repeat (4) begin
            stepCycle(nTable);
            @(negedge Clk);
        end
        if (errCount == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

// File: compile.f
+incdir+include
rtl/intIqPkg.sv
rtl/iqFreeList.sv
rtl/iqEntryArray.sv
rtl/iqSelect.sv
rtl/intIssueQueue.sv
sim/intIssueQueueTb.sv

// File: run.sh
#!/bin/sh
# build with verilator, run, then judge the log
rm -f sim.log
verilator --binary --timing --top-module intIssueQueueTb -f compile.f -o simv > build.log 2>&1 \
    && ./obj_dir/simv > sim.log 2>&1 \
    || cat build.log
cat sim.log 2>/dev/null
grep -q "Simulation FAILED" sim.log 2>/dev/null && exit 1
grep -q "Simulation PASSED" sim.log 2>/dev/null || exit 1
exit 0
